//--- armController.f
rtl/armCtrlPkg.sv
rtl/instrDecoder.sv
rtl/condUnit.sv
rtl/executeStage.sv
rtl/memWbPipe.sv
rtl/statusReg.sv
rtl/armController.sv
tb/armControllerTb.sv

//--- Bender.yml
package:
  name: armController

sources:
  - rtl/armCtrlPkg.sv
  - rtl/instrDecoder.sv
  - rtl/condUnit.sv
  - rtl/executeStage.sv
  - rtl/memWbPipe.sv
  - rtl/statusReg.sv
  - rtl/armController.sv
  - target: simulation
    files:
      - tb/armControllerTb.sv

//--- tb/armControllerTb.sv
`timescale 1ns/1ps

module armControllerTb;
  import armCtrlPkg::*;

  localparam logic [31:0] NOP_WORD  = 32'hF000_0000;   // Never-condition, no effects
  localparam logic [31:0] PSR_RESET = 32'h0000_0093;   // SVC mode, I set
  localparam int N_DP  = 16;
  localparam int N_FWD = 12;
  localparam int N_MEM = 12;
  // Five cycles per issued instruction, seven per forwarding pair, plus reset and margin
  localparam int MAX_CYCLES = 5 + (N_DP + N_MEM + 12) * 5 + N_FWD * 7 + 40 + 200;

  logic        clk = 1'b0;
  logic        rst;
  instrWordU   instrD;
  flagsT       aluFlagsE;
  logic [31:0] aluResultE;
  logic [31:0] aluOutW;
  logic        stallE, flushE, stallM, stallW, flushW;
  decCtrlT     decCtrlD;
  aluCtrlT     aluCtrlE;
  logic        branchTakenE;
  memCtrlT     memCtrlM;
  wbCtrlT      wbCtrlW;
  logic        memtoRegE, pcWrPending, undefinedInstr, swi;
  logic [31:0] cpsrW;

  logic [31:0] lfsr = 32'h73b55e4b;
  int          errCount = 0;
  int          testsRun = 0;
  int          testsFailed = 0;
  int          cycles = 0;
  flagsT       modelFlags;
  decCtrlT     decSnap;
  aluCtrlT     aluSnap;
  memCtrlT     memSnap;
  wbCtrlT      wbSnap;
  logic        swiSeen [0:3];
  logic        undefSeen [0:3];

  armController uut (.*);

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (cycles > MAX_CYCLES) begin
      $display("Timeout after %0d cycles, the tests did not complete", cycles);
      $display("Simulation failed");
      $finish;
    end
  end

  // ========================================
  // Helpers
  // ========================================
  // Fibonacci LFSR, one step per bit taken
  function automatic logic [31:0] randBits(input int n);
    logic        fb;
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];   // Taps 32, 22, 2, 1
      lfsr = {lfsr[30:0], fb};
      v    = {v[30:0], fb};
    end
    return v;
  endfunction

  task automatic step();
    @(posedge clk);
    #1;
  endtask

  task automatic checkEq(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      errCount++;
      $display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic endTest(input string name, input int errsBefore);
    testsRun++;
    if (errCount != errsBefore) testsFailed++;
    $display("Test %0d %s: %s", testsRun, name, (errCount == errsBefore) ? "ok" : "FAILED");
  endtask

  // Pairs of conditions share a base test, odd codes invert it
  function automatic logic condPass(input logic [3:0] c, input flagsT f);
    logic r;
    case (c[3:1])
      3'd0: r = f.z;
      3'd1: r = f.c;
      3'd2: r = f.n;
      3'd3: r = f.v;
      3'd4: r = f.c && !f.z;
      3'd5: r = (f.n == f.v);
      3'd6: r = (f.n == f.v) && !f.z;
      default: r = 1'b1;
    endcase
    if (c == 4'hF) return 1'b0;
    if (c[3:1] != 3'd7 && c[0]) r = !r;
    return r;
  endfunction

  function automatic flagsT nextFlags(input logic [3:0] op, input flagsT old, input flagsT alu);
    flagsT f;
    f = alu;
    case (op)
      4'h0, 4'h1, 4'h8, 4'h9, 4'hC, 4'hD, 4'hE, 4'hF: begin
        f.c = old.c;   // Logical ops keep C and V
        f.v = old.v;
      end
      default: ;
    endcase
    return f;
  endfunction

  // One-hot store lane, lane 0 at bit 0
  function automatic logic [3:0] laneMask(input logic [1:0] addr);
    logic [3:0] m;
    for (int k = 0; k < 4; k++) m[k] = (addr == k);
    return m;
  endfunction

  function automatic logic [31:0] dpWord(input logic [3:0] c, input logic imm,
      input logic [3:0] op, input logic s, input logic [3:0] rn, input logic [3:0] rd,
      input logic [11:0] op2);
    return {c, 2'b00, imm, op, s, rn, rd, op2};
  endfunction

  // Sends one word down an empty pipe and samples each stage
  task automatic issue(input logic [31:0] word, input flagsT flE, input logic [31:0] resE,
      input logic [31:0] outW);
    instrD = word;
    #1;
    decSnap = decCtrlD;
    swiSeen[0] = swi;
    undefSeen[0] = undefinedInstr;
    step();
    instrD = NOP_WORD;
    aluFlagsE = flE;
    aluResultE = resE;
    #1;
    aluSnap = aluCtrlE;
    swiSeen[1] = swi;
    undefSeen[1] = undefinedInstr;
    step();
    memSnap = memCtrlM;
    swiSeen[2] = swi;
    undefSeen[2] = undefinedInstr;
    step();
    wbSnap = wbCtrlW;
    aluOutW = outW;
    swiSeen[3] = swi;
    undefSeen[3] = undefinedInstr;
    step();                            // CPSR written here
  endtask

  // ========================================
  // Test sequence
  // ========================================
  initial begin
    logic [31:0] r, v;
    logic [3:0]  c, op, rd, bc;
    logic        s, cmp, pass;
    flagsT       fl, nf;
    int          e0;

    rst = 1'b1;
    instrD = NOP_WORD;
    aluFlagsE = '0;
    aluResultE = '0;
    aluOutW = '0;
    {stallE, flushE, stallM, stallW, flushW} = '0;
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;

    e0 = errCount;
    checkEq("cpsrW", cpsrW, PSR_RESET);
    checkEq("decCtrlD", decCtrlD, '0);
    checkEq("aluCtrlE", aluCtrlE, '0);
    checkEq("memCtrlM", memCtrlM, '0);
    checkEq("wbCtrlW", wbCtrlW, '0);
    checkEq("branchTakenE", branchTakenE, 0);
    checkEq("pcWrPending", pcWrPending, 0);
    checkEq("swi", swi, 0);
    checkEq("undefinedInstr", undefinedInstr, 0);
    modelFlags = PSR_RESET[31:28];
    endTest("reset state", e0);

    e0 = errCount;
    for (int i = 0; i < N_DP; i++) begin
      r = randBits(1);
      v = randBits(4);
      c = r[0] ? 4'hE : v[3:0];
      v = randBits(4);
      op = v[3:0];
      v = randBits(4);
      rd = (v[3:0] == 4'hF) ? 4'h3 : v[3:0];
      cmp = (op[3:2] == 2'b10);
      r = randBits(1);
      s = cmp ? 1'b1 : r[0];
      v = randBits(4);
      fl = v[3:0];
      r = randBits(17);
      pass = condPass(c, modelFlags);
      issue(dpWord(c, r[16], op, s, r[15:12], rd, r[11:0]), fl, 32'h0, 32'h0);
      checkEq("wbCtrlW.regWrite", wbSnap.regWrite, pass && !cmp);
      if (pass && s) modelFlags = nextFlags(op, modelFlags, fl);
      checkEq("cpsrW[31:28]", cpsrW[31:28], modelFlags);
    end
    endTest("data processing", e0);

    e0 = errCount;
    for (int i = 0; i < N_FWD; i++) begin
      v = randBits(4);
      op = v[3:0];
      v = randBits(4);
      fl = v[3:0];
      v = randBits(4);
      bc = v[3:0];
      nf = nextFlags(op, modelFlags, fl);
      instrD = dpWord(4'hE, 1'b1, op, 1'b1, 4'h1, 4'h2, 12'h005);
      step();
      aluFlagsE = fl;
      // Branch reaches E with the producer in M, W, then retired
      for (int t = 1; t <= 6; t++) begin
        if (t == (i % 3) + 2) checkEq("branchTakenE", branchTakenE, condPass(bc, nf));
        instrD = (t == (i % 3) + 1) ? {bc, 4'b1010, 24'h000010} : NOP_WORD;
        #1;
        if (t == (i % 3) + 1) begin
          // PC as base with the 24-bit offset, fetch redirect pending
          checkEq("decCtrlD", decCtrlD, 4'b0110);
          checkEq("pcWrPending", pcWrPending, 1);
        end
        step();
      end
      modelFlags = nf;
      checkEq("cpsrW[31:28]", cpsrW[31:28], modelFlags);
    end
    endTest("flags and branches", e0);

    e0 = errCount;
    for (int i = 0; i < N_MEM; i++) begin
      r = randBits(32);
      v = randBits(4);
      // Byte store, word store, then load in turn
      case (i % 3)
        0: issue({4'hE, 3'b010, 1'b1, v[0], 1'b1, 1'b0, 1'b0, 4'h1, 4'h2, 12'h004}, '0, r, 0);
        1: issue({4'hE, 3'b010, 1'b1, v[0], 1'b0, 1'b0, 1'b0, 4'h1, 4'h2, 12'h008}, '0, r, 0);
        default: issue({4'hE, 3'b010, 1'b1, v[0], v[1], 1'b0, 1'b1, 4'h1, 4'h2, 12'h00C},
                       '0, r, 0);
      endcase
      checkEq("aluCtrlE", aluSnap, {27'h0, 1'b1, (v[0] ? 4'h4 : 4'h2)});   // Up adds
      if (i % 3 == 2) begin
        checkEq("decCtrlD", decSnap, 4'b0001);
        checkEq("wbCtrlW.memtoReg", wbSnap.memtoReg, 1);
        checkEq("wbCtrlW.loadByte", wbSnap.loadByte, v[1]);
        checkEq("memCtrlM.memWrite", memSnap.memWrite, 0);
      end else begin
        checkEq("decCtrlD", decSnap, 4'b1001);   // Stores read Rd as data
        checkEq("memCtrlM.memWrite", memSnap.memWrite, 1);
        checkEq("memCtrlM.byteMask", memSnap.byteMask,
                (i % 3 == 0) ? laneMask(r[1:0]) : 4'hF);
      end
    end
    endTest("loads and stores", e0);

    e0 = errCount;
    r = randBits(32);
    r[7] = 1'b0;                       // I clear, the exception below has to set it
    issue(dpWord(4'hE, 1'b1, 4'b1001, 1'b0, 4'b1001, 4'hF, 12'h000), '0, r, r);
    checkEq("cpsrW[31:28]", cpsrW[31:28], r[31:28]);
    checkEq("cpsrW[7:0]", cpsrW[7:0], r[7:0]);
    modelFlags = r[31:28];
    issue(dpWord(4'hE, 1'b0, 4'b1000, 1'b0, 4'hF, 4'h4, 12'h000), '0, 0, 0);
    checkEq("wbCtrlW.cpsrToReg", wbSnap.cpsrToReg, 1);
    endTest("MSR and MRS", e0);

    e0 = errCount;
    issue({4'hE, 3'b011, 5'h00, 4'h1, 4'h2, 12'h010}, '0, 0, 0);
    for (int k = 0; k < 4; k++) checkEq("undefinedInstr", undefSeen[k], 1);
    checkEq("cpsrW[7]", cpsrW[7], 1);
    checkEq("cpsrW[4:0]", cpsrW[4:0], 5'b11011);
    // Control-only MSR back to user mode with I clear
    issue(dpWord(4'hE, 1'b1, 4'b1001, 1'b0, 4'b0001, 4'hF, 12'h000), '0, 0, 32'h10);
    checkEq("cpsrW[7:0]", cpsrW[7:0], 8'h10);
    checkEq("cpsrW[31:28]", cpsrW[31:28], modelFlags);
    issue({4'hE, 4'hF, 24'h000042}, '0, 0, 0);
    for (int k = 0; k < 4; k++) checkEq("swi", swiSeen[k], 1);
    checkEq("cpsrW[7]", cpsrW[7], 1);
    checkEq("cpsrW[4:0]", cpsrW[4:0], 5'b10011);
    endTest("exceptions", e0);

    e0 = errCount;
    instrD = {4'hE, 3'b010, 1'b1, 1'b1, 1'b0, 1'b0, 1'b1, 4'h1, 4'h2, 12'h000};
    step();
    instrD = NOP_WORD;
    stallE = 1'b1;
    r = {27'h0, 1'b1, 4'h4};          // Immediate offset, up, so ADD
    repeat (3) begin
      step();
      checkEq("memtoRegE", memtoRegE, 1);
      checkEq("aluCtrlE", aluCtrlE, r);
    end
    stallE = 1'b0;
    repeat (4) step();
    instrD = dpWord(4'hE, 1'b1, 4'hD, 1'b0, 4'h0, 4'h1, 12'h001);
    flushE = 1'b1;
    step();
    flushE = 1'b0;
    instrD = NOP_WORD;
    repeat (2) step();
    checkEq("wbCtrlW.regWrite", wbCtrlW.regWrite, 0);
    instrD = dpWord(4'hE, 1'b1, 4'hD, 1'b0, 4'h0, 4'h1, 12'h001);
    step();
    instrD = NOP_WORD;
    step();
    checkEq("memCtrlM.regWrite", memCtrlM.regWrite, 1);
    flushW = 1'b1;
    step();
    flushW = 1'b0;
    checkEq("wbCtrlW.regWrite", wbCtrlW.regWrite, 0);
    repeat (2) step();
    endTest("stall and flush", e0);

    $display("Tests run %0d, tests failed %0d, check errors %0d",
             testsRun, testsFailed, errCount);
    if (errCount == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- rtl/armController.sv
`timescale 1ns/1ps

module armController (
  input  logic                  clk,
  input  logic                  rst,
  input  armCtrlPkg::instrWordU instrD,
  input  armCtrlPkg::flagsT     aluFlagsE,
  input  logic [31:0]           aluResultE,
  input  logic [31:0]           aluOutW,
  input  logic                  stallE,
  input  logic                  flushE,
  input  logic                  stallM,
  input  logic                  stallW,
  input  logic                  flushW,
  output armCtrlPkg::decCtrlT   decCtrlD,
  output armCtrlPkg::aluCtrlT   aluCtrlE,
  output logic                  branchTakenE,
  output armCtrlPkg::memCtrlT   memCtrlM,
  output armCtrlPkg::wbCtrlT    wbCtrlW,
  output logic                  memtoRegE,
  output logic                  pcWrPending,
  output logic                  undefinedInstr,
  output logic                  swi,
  output logic [31:0]           cpsrW
);
  import armCtrlPkg::*;

  exCtrlT  exNextD;
  memCtrlT memNextE;
  psrUpdT  psrNextE;
  psrUpdT  psrM;
  psrUpdT  psrW;
  flagsT   cpsrFlags;
  logic    pcSrcE;

  assign cpsrFlags = cpsrW[31:28];

  instrDecoder decoder (.instrD(instrD), .decCtrlD(decCtrlD), .exNextD(exNextD));

  executeStage execute (
    .clk(clk), .rst(rst), .stallE(stallE), .flushE(flushE),
    .exNextD(exNextD), .aluFlagsE(aluFlagsE), .aluResultE(aluResultE),
    .flagsNextM(psrM.flagsNext), .setFlagsM(psrM.setFlags),
    .flagsNextW(psrW.flagsNext), .setFlagsW(psrW.setFlags),
    .cpsrFlags(cpsrFlags), .aluCtrlE(aluCtrlE), .branchTakenE(branchTakenE),
    .memtoRegE(memtoRegE), .pcSrcE(pcSrcE), .memNextE(memNextE), .psrNextE(psrNextE)
  );

  memWbPipe memWb (
    .clk(clk), .rst(rst), .stallM(stallM), .stallW(stallW), .flushW(flushW),
    .memNextE(memNextE), .psrNextE(psrNextE),
    .memCtrlM(memCtrlM), .psrM(psrM), .wbCtrlW(wbCtrlW), .psrW(psrW)
  );

  statusReg cpsr (
    .clk(clk), .rst(rst), .stallW(stallW), .psrW(psrW), .aluOutW(aluOutW), .cpsrW(cpsrW)
  );

  // ========================================
  // Hazard unit outputs
  // ========================================
  assign undefinedInstr = exNextD.undef | psrNextE.undef | psrM.undef | psrW.undef;
  assign swi            = exNextD.swi | psrNextE.swi | psrM.swi | psrW.swi;
  assign pcWrPending    = exNextD.pcSrc | pcSrcE | memCtrlM.pcSrc;   // Fetch waits on these

endmodule

//--- rtl/statusReg.sv
`timescale 1ns/1ps

module statusReg (
  input  logic               clk,
  input  logic               rst,
  input  logic               stallW,
  input  armCtrlPkg::psrUpdT psrW,
  input  logic [31:0]        aluOutW,
  output logic [31:0]        cpsrW
);
  import armCtrlPkg::*;

  flagsT      flagsQ;
  logic [7:0] ctrlQ;     // I, F, T and mode

  always_ff @(posedge clk) begin
    if (rst) begin
      flagsQ <= RESET_PSR[31:28];
      ctrlQ  <= RESET_PSR[7:0];
    end else if (!stallW) begin
      // Exceptions take priority over an MSR write
      if (psrW.undef) begin
        ctrlQ[7]   <= 1'b1;
        ctrlQ[4:0] <= MODE_UND;
      end else if (psrW.swi) begin
        ctrlQ[7]   <= 1'b1;
        ctrlQ[4:0] <= MODE_SVC;
      end else if (psrW.msrMask[0]) begin
        ctrlQ <= aluOutW[7:0];
      end

      if (psrW.setFlags) begin
        flagsQ <= psrW.flagsNext;
      end
    end
  end

  // Reserved bits stay at their reset value
  assign cpsrW = {flagsQ, RESET_PSR[27:8], ctrlQ};

endmodule

//--- rtl/memWbPipe.sv
`timescale 1ns/1ps

module memWbPipe (
  input  logic                clk,
  input  logic                rst,
  input  logic                stallM,
  input  logic                stallW,
  input  logic                flushW,
  input  armCtrlPkg::memCtrlT memNextE,
  input  armCtrlPkg::psrUpdT  psrNextE,
  output armCtrlPkg::memCtrlT memCtrlM,
  output armCtrlPkg::psrUpdT  psrM,
  output armCtrlPkg::wbCtrlT  wbCtrlW,
  output armCtrlPkg::psrUpdT  psrW
);
  import armCtrlPkg::*;

  wbCtrlT wbNextM;

  // E to M, no flush here
  always_ff @(posedge clk) begin
    if (rst) begin
      memCtrlM <= '0;
      psrM     <= '0;
    end else if (!stallM) begin
      memCtrlM <= memNextE;
      psrM     <= psrNextE;
    end
  end

  // Byte access becomes the load width for the aligner
  assign wbNextM = '{memtoReg:   memCtrlM.memtoReg,
                     regWrite:   memCtrlM.regWrite,
                     pcSrc:      memCtrlM.pcSrc,
                     loadByte:   memCtrlM.byteAccess,
                     byteOffset: memCtrlM.byteOffset,
                     cpsrToReg:  memCtrlM.cpsrToReg};

  always_ff @(posedge clk) begin
    if (rst || flushW) begin
      wbCtrlW <= '0;
      psrW    <= '0;
    end else if (!stallW) begin
      wbCtrlW <= wbNextM;
      psrW    <= psrM;
    end
  end

endmodule

//--- rtl/executeStage.sv
`timescale 1ns/1ps

module executeStage (
  input  logic                clk,
  input  logic                rst,
  input  logic                stallE,
  input  logic                flushE,
  input  armCtrlPkg::exCtrlT  exNextD,
  input  armCtrlPkg::flagsT   aluFlagsE,
  input  logic [31:0]         aluResultE,
  input  armCtrlPkg::flagsT   flagsNextM,
  input  logic                setFlagsM,
  input  armCtrlPkg::flagsT   flagsNextW,
  input  logic                setFlagsW,
  input  armCtrlPkg::flagsT   cpsrFlags,
  output armCtrlPkg::aluCtrlT aluCtrlE,
  output logic                branchTakenE,
  output logic                memtoRegE,
  output logic                pcSrcE,
  output armCtrlPkg::memCtrlT memNextE,
  output armCtrlPkg::psrUpdT  psrNextE
);
  import armCtrlPkg::*;

  exCtrlT exE;
  flagsT  flagsE;
  flagsT  condFlagsNext;
  logic   condExE;
  logic   isCompareE;
  logic   msrE;
  logic   msrFlagsE;

  // ========================================
  // D to E register
  // ========================================
  always_ff @(posedge clk) begin
    if (rst || flushE) begin
      exE <= '0;                       // Bubble
    end else if (!stallE) begin
      exE <= exNextD;
    end
  end

  // Youngest pending flag producer wins
  assign flagsE = setFlagsM ? flagsNextM : (setFlagsW ? flagsNextW : cpsrFlags);

  condUnit condCheck (
    .cond      (exE.cond),
    .flags     (flagsE),
    .aluFlags  (aluFlagsE),
    .aluOp     (exE.aluControl),
    .flagWrite (exE.flagWrite),
    .condEx    (condExE),
    .flagsNext (condFlagsNext)
  );

  // Compares always carry S, which keeps MRS out of this set
  assign isCompareE = (exE.instr.dpView.instrClass == 2'b00) && exE.instr.dpView.sBit
                   && (aluOpT'(exE.instr.dpView.opcode) inside {OP_TST, OP_TEQ, OP_CMP, OP_CMN});

  assign msrE      = exE.regToCpsr && condExE;
  assign msrFlagsE = msrE && exE.msrMask[1];

  assign aluCtrlE     = '{aluSrc: exE.aluSrc, aluControl: exE.aluControl};
  assign branchTakenE = exE.branch && condExE;
  assign memtoRegE    = exE.memtoReg;
  assign pcSrcE       = exE.pcSrc;   // Ungated, used as a pending hint

  // ========================================
  // Gated controls toward M
  // ========================================
  always_comb begin
    memNextE            = '0;
    memNextE.memWrite   = exE.memWrite && condExE;
    memNextE.memtoReg   = exE.memtoReg;
    memNextE.regWrite   = exE.regWrite && condExE && !isCompareE;
    memNextE.pcSrc      = exE.pcSrc && condExE && !isCompareE;
    memNextE.byteAccess = exE.byteAccess;
    memNextE.byteOffset = aluResultE[1:0];
    memNextE.cpsrToReg  = exE.cpsrToReg && condExE;
    if (memNextE.memWrite) begin
      memNextE.byteMask = exE.byteAccess ? (4'b0001 << aluResultE[1:0]) : 4'b1111;
    end
  end

  always_comb begin
    psrNextE           = '0;
    psrNextE.flagsNext = msrFlagsE ? flagsT'(aluResultE[31:28]) : condFlagsNext;
    psrNextE.setFlags  = (exE.flagWrite && condExE) || msrFlagsE;
    psrNextE.msrMask   = msrE ? exE.msrMask : 2'b00;
    psrNextE.undef     = exE.undef;
    psrNextE.swi       = exE.swi;
  end

endmodule

//--- rtl/condUnit.sv
`timescale 1ns/1ps

module condUnit (
  input  armCtrlPkg::condCodeT cond,
  input  armCtrlPkg::flagsT    flags,
  input  armCtrlPkg::flagsT    aluFlags,
  input  armCtrlPkg::aluOpT    aluOp,
  input  logic                 flagWrite,
  output logic                 condEx,
  output armCtrlPkg::flagsT    flagsNext
);
  import armCtrlPkg::*;

  always_comb begin
    case (cond)
      COND_EQ: condEx = flags.z;
      COND_NE: condEx = !flags.z;
      COND_CS: condEx = flags.c;
      COND_CC: condEx = !flags.c;
      COND_MI: condEx = flags.n;
      COND_PL: condEx = !flags.n;
      COND_VS: condEx = flags.v;
      COND_VC: condEx = !flags.v;
      COND_HI: condEx = flags.c && !flags.z;
      COND_LS: condEx = !flags.c || flags.z;
      COND_GE: condEx = (flags.n == flags.v);
      COND_LT: condEx = (flags.n != flags.v);
      COND_GT: condEx = !flags.z && (flags.n == flags.v);
      COND_LE: condEx = flags.z || (flags.n != flags.v);
      COND_AL: condEx = 1'b1;
      default: condEx = 1'b0;           // NV never executes
    endcase
  end

  always_comb begin
    flagsNext = flags;
    if (condEx && flagWrite) begin
      if (aluOp inside {OP_AND, OP_EOR, OP_TST, OP_TEQ, OP_ORR, OP_MOV, OP_BIC, OP_MVN}) begin
        flagsNext.n = aluFlags.n;   // C and V kept for logical ops
        flagsNext.z = aluFlags.z;
      end else begin
        flagsNext = aluFlags;
      end
    end
  end

endmodule

//--- rtl/instrDecoder.sv
`timescale 1ns/1ps

module instrDecoder (
  input  armCtrlPkg::instrWordU instrD,
  output armCtrlPkg::decCtrlT   decCtrlD,
  output armCtrlPkg::exCtrlT    exNextD
);
  import armCtrlPkg::*;

  dpViewT  dp;
  memViewT mem;
  logic    isMsr;
  logic    isMrs;
  logic    isUndef;
  logic    isSwi;

  assign dp  = instrD.dpView;
  assign mem = instrD.memView;

  // Status moves sit in the compare opcode space with S clear
  assign isMsr = (dp.instrClass == 2'b00) && (dp.opcode[3:2] == 2'b10) && dp.opcode[0]
              && !dp.sBit && (dp.rd == 4'hF);
  assign isMrs = (dp.instrClass == 2'b00) && !dp.imm && (dp.opcode[3:2] == 2'b10)
              && !dp.opcode[0] && !dp.sBit && (dp.rn == 4'hF);

  // Register offset with bit 4 set is not a legal transfer
  assign isUndef = (mem.instrClass == 2'b01) && mem.regOffset && mem.offset[4];
  assign isSwi   = (instrD[27:24] == 4'hF);

  always_comb begin
    decCtrlD = '0;
    exNextD  = '0;

    exNextD.cond       = condCodeT'(dp.cond);
    exNextD.instr      = instrD;
    exNextD.aluControl = OP_ADD;     // Default for branch and the rest
    exNextD.undef      = isUndef;
    exNextD.swi        = isSwi;

    case (dp.instrClass)
      2'b00: begin
        exNextD.aluSrc = dp.imm;
        if (isMsr) begin
          exNextD.aluControl = OP_MOV;   // Pass operand B through
          exNextD.regToCpsr  = 1'b1;
          exNextD.msrMask    = {dp.rn[3], dp.rn[0]};
        end else if (isMrs) begin
          exNextD.regWrite  = 1'b1;
          exNextD.cpsrToReg = 1'b1;
        end else begin
          exNextD.aluControl = aluOpT'(dp.opcode);
          exNextD.regWrite   = 1'b1;
          exNextD.flagWrite  = dp.sBit;
        end
      end

      2'b01: begin
        if (!isUndef) begin
          decCtrlD.immSrc    = 2'b01;
          decCtrlD.regSrc    = mem.load ? 2'b00 : 2'b10;  // Stores read Rd as data
          exNextD.aluSrc     = !mem.regOffset;
          exNextD.aluControl = mem.up ? OP_ADD : OP_SUB;
          exNextD.memtoReg   = mem.load;
          exNextD.regWrite   = mem.load;
          exNextD.memWrite   = !mem.load;
          exNextD.byteAccess = mem.byteBit;
        end
      end

      2'b10: begin
        decCtrlD.regSrc = 2'b01;     // PC as base
        decCtrlD.immSrc = 2'b10;     // 24-bit branch offset
        exNextD.aluSrc  = 1'b1;
        exNextD.branch  = 1'b1;
      end

      default: begin
        // SWI carries no datapath control
      end
    endcase

    // Writes to R15 redirect fetch
    exNextD.pcSrc = exNextD.branch
                 || (exNextD.regWrite && (dp.rd == 4'hF) && !exNextD.cpsrToReg);
  end

endmodule

//--- rtl/armCtrlPkg.sv
package armCtrlPkg;

  // ========================================
  // Instruction word
  // ========================================
  typedef struct packed {
    logic [3:0]  cond;
    logic [1:0]  instrClass;
    logic        imm;        // Operand2 is an immediate
    logic [3:0]  opcode;
    logic        sBit;
    logic [3:0]  rn;
    logic [3:0]  rd;
    logic [11:0] operand2;
  } dpViewT;

  typedef struct packed {
    logic [3:0]  cond;
    logic [1:0]  instrClass;
    logic        regOffset;  // Offset taken from a register
    logic        pre;
    logic        up;         // Add offset when set
    logic        byteBit;
    logic        writeBack;
    logic        load;
    logic [3:0]  rn;
    logic [3:0]  rd;
    logic [11:0] offset;
  } memViewT;

  // Same word, read as data processing or as load/store
  typedef union packed {
    dpViewT  dpView;
    memViewT memView;
  } instrWordU;

  typedef enum logic [3:0] {
    OP_AND = 4'h0, OP_EOR = 4'h1, OP_SUB = 4'h2, OP_RSB = 4'h3,
    OP_ADD = 4'h4, OP_ADC = 4'h5, OP_SBC = 4'h6, OP_RSC = 4'h7,
    OP_TST = 4'h8, OP_TEQ = 4'h9, OP_CMP = 4'hA, OP_CMN = 4'hB,
    OP_ORR = 4'hC, OP_MOV = 4'hD, OP_BIC = 4'hE, OP_MVN = 4'hF
  } aluOpT;

  typedef enum logic [3:0] {
    COND_EQ = 4'h0, COND_NE = 4'h1, COND_CS = 4'h2, COND_CC = 4'h3,
    COND_MI = 4'h4, COND_PL = 4'h5, COND_VS = 4'h6, COND_VC = 4'h7,
    COND_HI = 4'h8, COND_LS = 4'h9, COND_GE = 4'hA, COND_LT = 4'hB,
    COND_GT = 4'hC, COND_LE = 4'hD, COND_AL = 4'hE
  } condCodeT;

  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
  } flagsT;

  // ========================================
  // Pipeline control bundles
  // ========================================
  typedef struct packed {
    logic [1:0] regSrc;
    logic [1:0] immSrc;
  } decCtrlT;

  typedef struct packed {
    logic       aluSrc;
    aluOpT      aluControl;
    logic       memWrite;
    logic       memtoReg;
    logic       regWrite;
    logic       branch;
    logic       pcSrc;
    logic       flagWrite;
    logic       byteAccess;
    logic       cpsrToReg;   // MRS
    logic       regToCpsr;   // MSR
    logic [1:0] msrMask;     // {flags, control}
    logic       undef;
    logic       swi;
    condCodeT   cond;
    instrWordU  instr;
  } exCtrlT;

  typedef struct packed {
    logic  aluSrc;
    aluOpT aluControl;
  } aluCtrlT;

  typedef struct packed {
    logic       memWrite;
    logic       memtoReg;
    logic       regWrite;
    logic       pcSrc;
    logic [3:0] byteMask;    // Lane 0 at bit 0
    logic       byteAccess;
    logic [1:0] byteOffset;
    logic       cpsrToReg;
  } memCtrlT;

  typedef struct packed {
    logic       memtoReg;
    logic       regWrite;
    logic       pcSrc;
    logic       loadByte;
    logic [1:0] byteOffset;
    logic       cpsrToReg;
  } wbCtrlT;

  typedef struct packed {
    flagsT      flagsNext;
    logic       setFlags;
    logic [1:0] msrMask;
    logic       undef;
    logic       swi;
  } psrUpdT;

  typedef logic [4:0] modeT;

  localparam modeT MODE_USR = 5'b10000;
  localparam modeT MODE_SVC = 5'b10011;
  localparam modeT MODE_UND = 5'b11011;

  // Supervisor mode with IRQ masked
  localparam logic [31:0] RESET_PSR = {4'b0000, 20'h00000, 1'b1, 2'b00, MODE_SVC};

endpackage
